//--- source/fetch_pkg.sv
//////////////////////////////
// shared widths, types and host register map for the fetch front end
// two-slot fetch only; every size is a localparam here
//////////////////////////////
`default_nettype none

package fetch_pkg;

  //////////////////////////////
  // widths with a meaning
  //////////////////////////////
  typedef logic [63:0] pc_t;            // byte address of an instruction
  typedef logic [31:0] inst_t;          // one instruction
  typedef logic [63:0] mem_word_t;      // two instructions, slot 0 in the low half
  typedef logic [31:0] host_data_t;     // host bus data
  typedef logic [7:0]  host_addr_t;     // host word address
  typedef logic [5:0]  imem_addr_t;     // RAM word index
  typedef logic [31:0] bundle_count_t;  // delivered bundles

  // sizes
  localparam int unsigned FETCH_WIDTH = 2;   // slots per bundle
  localparam int unsigned IMEM_WORDS  = 64;  // RAM depth in 64-bit words

  //////////////////////////////
  // host register map
  //////////////////////////////
  localparam host_addr_t HOST_CTRL_ADDR    = 8'h00;  // bit 0 is run
  localparam host_addr_t HOST_BOOT_PC_ADDR = 8'h01;  // boot pc, zero-extended
  localparam host_addr_t HOST_COUNT_ADDR   = 8'h02;  // bundle count, read only
  localparam host_addr_t HOST_IMEM_BASE    = 8'h80;  // even = low half, odd = high half

  // fetch bus master states
  typedef enum logic
  {
    bus_idle,  // no read in flight
    bus_wait   // cyc and stb up, waiting for ack
  } bus_state_t;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
//////////////////////////////
// fetch stage: pc register and two-slot bundle split
// pc must be 4-byte aligned; redirects come from outside
// outputs are combinational from pc and the held memory word
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module fetch_stage
  import fetch_pkg::*;
(
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         get_next_inst,  // consumer takes the bundle
  input  logic                         take_branch,    // redirect to branch_target
  input  pc_t                          branch_target,
  input  logic                         restart,        // one-cycle pulse from run rising
  input  pc_t                          boot_pc,
  input  mem_word_t                    imem_data,
  input  logic                         imem_valid,
  output pc_t                          fetch_addr,     // 8-byte aligned word address
  output pc_t   [FETCH_WIDTH-1:0]      if_pc,
  output pc_t   [FETCH_WIDTH-1:0]      if_npc,
  output inst_t [FETCH_WIDTH-1:0]      if_ir,
  output logic  [FETCH_WIDTH-1:0]      if_valid
);

  pc_t  pc_reg;     // pc of slot 0 of the current bundle
  pc_t  pc_plus;    // sequential next pc
  pc_t  next_pc;
  logic pc_enable;

  assign fetch_addr = {pc_reg[63:3], 3'b000};

  // an odd-slot pc only has one instruction left in its word
  assign pc_plus = pc_reg[2] ? (pc_reg + pc_t'(4)) : (pc_reg + pc_t'(FETCH_WIDTH * 4));

  //////////////////////////////
  // next pc selection
  //////////////////////////////
  always_comb
  begin
    if (restart)
      next_pc = boot_pc;        // run just went high
    else if (take_branch)
      next_pc = branch_target;  // redirect beats stall
    else
      next_pc = pc_plus;
  end

  assign pc_enable = restart || take_branch || (imem_valid && get_next_inst);

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= '0;
    else if (pc_enable)
      pc_reg <= next_pc;
  end

  //////////////////////////////
  // bundle outputs
  //////////////////////////////
  assign if_ir[0] = imem_data[31:0];   // low half is slot 0
  assign if_ir[1] = imem_data[63:32];

  assign if_pc[0] = pc_reg;
  assign if_pc[1] = pc_reg + pc_t'(4);

  // slot 0 npc follows the reference convention
  assign if_npc[0] = pc_reg;
  assign if_npc[1] = pc_plus;

  assign if_valid[0] = imem_valid && !pc_reg[2];  // skipped when entering mid-word
  assign if_valid[1] = imem_valid;

  // control block only raises restart on a host write, branches come from the core
  redirect_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(take_branch && restart))
    else $error("take_branch and restart high together");

endmodule

`default_nettype wire

//--- source/imem_bus_master.sv
//////////////////////////////
// wishbone classic read master for fetch words
// holds one word tagged with its address and has no faults or retries
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module imem_bus_master
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       run,         // fetch enabled
  input  pc_t        fetch_addr,  // word wanted by the fetch stage
  input  mem_word_t  fetch_dat,
  input  logic       fetch_ack,
  output logic       fetch_cyc,
  output logic       fetch_stb,
  output imem_addr_t fetch_adr,
  output mem_word_t  imem_data,
  output logic       imem_valid
);

  bus_state_t state;
  pc_t        req_pc;      // address of the read in flight
  pc_t        held_tag;    // address the held word came from
  mem_word_t  held_data;
  logic       held_valid;
  logic       hit;

  assign hit        = held_valid && (held_tag == fetch_addr);
  assign imem_valid = run && hit;  // stale word after a redirect never passes
  assign imem_data  = held_data;

  // cyc and stb track the wait state, so they hold until ack
  assign fetch_cyc = (state == bus_wait);
  assign fetch_stb = (state == bus_wait);
  assign fetch_adr = req_pc[3 +: $bits(imem_addr_t)];

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state      <= bus_idle;
      held_valid <= 1'b0;
    end
    else
    begin
      case (state)
        bus_idle:
        begin
          if (!run)
            held_valid <= 1'b0;  // ram may be reloaded while stopped
          else if (!hit)
            state <= bus_wait;
        end
        bus_wait:
        begin
          if (fetch_ack)
          begin
            state      <= bus_idle;
            held_valid <= run;
          end
        end
        default: state <= bus_idle;
      endcase
    end
  end

  // request address and returned word
  always_ff @(posedge clock)
  begin
    if (state == bus_idle && run && !hit)
      req_pc <= fetch_addr;
    if (state == bus_wait && fetch_ack)
    begin
      held_data <= fetch_dat;
      held_tag  <= req_pc;  // tag with what was asked, not the current pc
    end
  end

  // the RAM answers only an open strobe
  ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
    fetch_ack |-> fetch_cyc && fetch_stb)
    else $error("fetch_ack without an open fetch cycle");

endmodule

`default_nettype wire

//--- source/inst_ram.sv
//////////////////////////////
// 64-bit instruction RAM, wishbone classic read port
// one wait state on every read; host writes one 32-bit half per cycle
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module inst_ram
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       fetch_cyc,
  input  logic       fetch_stb,
  input  imem_addr_t fetch_adr,
  input  logic       ram_we,     // host write strobe
  input  imem_addr_t ram_adr,
  input  logic       ram_half,   // 1 = high half
  input  inst_t      ram_dat,
  output mem_word_t  fetch_dat,
  output logic       fetch_ack
);

  mem_word_t mem [IMEM_WORDS];
  logic      fetch_req;

  // first cycle of a strobe, the ack cycle itself does not count
  assign fetch_req = fetch_cyc && fetch_stb && !fetch_ack;

  //////////////////////////////
  // read port
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      fetch_ack <= 1'b0;
    else
      fetch_ack <= fetch_req;  // single-cycle ack
  end

  always_ff @(posedge clock)
  begin
    if (fetch_req)
      fetch_dat <= mem[fetch_adr];  // ready together with ack
  end

  // host write port
  always_ff @(posedge clock)
  begin
    if (ram_we)
    begin
      if (ram_half)
        mem[ram_adr][63:32] <= ram_dat;
      else
        mem[ram_adr][31:0] <= ram_dat;
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_control.sv
//////////////////////////////
// host register block for run, boot pc, bundle count and RAM loads
// every strobe is acked one cycle later and unmapped writes are dropped
// RAM words are write only from the host side
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module fetch_control
  import fetch_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   host_cyc,
  input  logic                   host_stb,
  input  logic                   host_we,
  input  host_addr_t             host_adr,
  input  host_data_t             host_dat_w,
  input  logic [FETCH_WIDTH-1:0] if_valid,
  input  logic                   get_next_inst,
  output host_data_t             host_dat_r,
  output logic                   host_ack,
  output logic                   run,
  output logic                   restart,     // run rising edge
  output pc_t                    boot_pc,
  output logic                   ram_we,
  output imem_addr_t             ram_adr,
  output logic                   ram_half,
  output inst_t                  ram_dat
);

  host_data_t    boot_pc_reg;
  bundle_count_t bundle_count;
  host_addr_t    imem_off;   // offset into the RAM window
  logic          host_req;   // first cycle of a host strobe
  logic          ctrl_write;

  assign host_req   = host_cyc && host_stb && !host_ack;
  assign ctrl_write = host_req && host_we && (host_adr == HOST_CTRL_ADDR);
  assign boot_pc    = pc_t'(boot_pc_reg);  // zero-extend

  //////////////////////////////
  // RAM load routing
  //////////////////////////////
  assign imem_off = host_adr - HOST_IMEM_BASE;
  assign ram_we   = host_req && host_we && (host_adr >= HOST_IMEM_BASE);
  assign ram_adr  = imem_off[6:1];  // two host words per RAM word
  assign ram_half = imem_off[0];    // odd address is the high half
  assign ram_dat  = host_dat_w;

  // registers and ack
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      host_ack    <= 1'b0;
      run         <= 1'b0;
      restart     <= 1'b0;
      boot_pc_reg <= '0;
    end
    else
    begin
      host_ack <= host_req;
      restart  <= ctrl_write && host_dat_w[0] && !run;  // 0 -> 1 only
      if (ctrl_write)
        run <= host_dat_w[0];
      if (host_req && host_we && host_adr == HOST_BOOT_PC_ADDR)
        boot_pc_reg <= host_dat_w;
    end
  end

  // registered read mux so data arrives with ack
  always_ff @(posedge clock)
  begin
    if (host_req && !host_we)
    begin
      case (host_adr)
        HOST_CTRL_ADDR:    host_dat_r <= {31'b0, run};
        HOST_BOOT_PC_ADDR: host_dat_r <= boot_pc_reg;
        HOST_COUNT_ADDR:   host_dat_r <= bundle_count;
        default:           host_dat_r <= '0;
      endcase
    end
  end

  //////////////////////////////
  // bundle counter
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      bundle_count <= '0;
    else if (get_next_inst && |if_valid)
      bundle_count <= bundle_count + 1'b1;  // one per accepted bundle
  end

  // the host keeps its strobe up until the ack
  host_strobe_held: assert property (@(posedge clock) disable iff (reset)
    host_req |=> host_cyc && host_stb)
    else $error("host strobe dropped before host_ack");

endmodule

`default_nettype wire

//--- source/fetch_top.sv
//////////////////////////////
// fetch front end top level
// host bus loads RAM and sets run before any fetch starts
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  // host bus
  input  logic                   host_cyc,
  input  logic                   host_stb,
  input  logic                   host_we,
  input  host_addr_t             host_adr,
  input  host_data_t             host_dat_w,
  output host_data_t             host_dat_r,
  output logic                   host_ack,
  // core side
  input  logic                   get_next_inst,
  input  logic                   take_branch,
  input  pc_t                    branch_target,
  output pc_t   [FETCH_WIDTH-1:0] if_pc,
  output pc_t   [FETCH_WIDTH-1:0] if_npc,
  output inst_t [FETCH_WIDTH-1:0] if_ir,
  output logic  [FETCH_WIDTH-1:0] if_valid
);

  logic       run, restart;
  pc_t        boot_pc, fetch_addr;
  mem_word_t  imem_data, fetch_dat;
  logic       imem_valid;
  logic       fetch_cyc, fetch_stb, fetch_ack;
  imem_addr_t fetch_adr, ram_adr;
  logic       ram_we, ram_half;
  inst_t      ram_dat;

  fetch_stage u_fetch_stage (
    .clock, .reset, .get_next_inst, .take_branch, .branch_target,
    .restart, .boot_pc, .imem_data, .imem_valid,
    .fetch_addr, .if_pc, .if_npc, .if_ir, .if_valid
  );

  imem_bus_master u_imem_bus_master (
    .clock, .reset, .run, .fetch_addr, .fetch_dat, .fetch_ack,
    .fetch_cyc, .fetch_stb, .fetch_adr, .imem_data, .imem_valid
  );

  inst_ram u_inst_ram (
    .clock, .reset, .fetch_cyc, .fetch_stb, .fetch_adr,
    .ram_we, .ram_adr, .ram_half, .ram_dat, .fetch_dat, .fetch_ack
  );

  fetch_control u_fetch_control (
    .clock, .reset, .host_cyc, .host_stb, .host_we, .host_adr, .host_dat_w,
    .if_valid, .get_next_inst, .host_dat_r, .host_ack, .run, .restart,
    .boot_pc, .ram_we, .ram_adr, .ram_half, .ram_dat
  );

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
//////////////////////////////
// testbench for the fetch front end
// loads 128 LFSR instructions over the host bus, then runs random stalls
// and branches; RAM addresses alias modulo 512 bytes
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
;

  localparam int            CLOCK_PERIOD = 100;
  localparam int            RESET_CYCLES = 8;
  localparam bundle_count_t NUM_BUNDLES  = 300;
  localparam int            LOAD_CYCLES  = 128 * 4 + 64;  // host writes plus readbacks
  localparam int            WATCHDOG_CYCLES = RESET_CYCLES + LOAD_CYCLES + 40 * NUM_BUNDLES;
  localparam host_data_t    BOOT_PC = 32'h0000_0010;      // start of word 2

  logic clock;
  logic reset;
  logic host_cyc, host_stb, host_we, host_ack;
  host_addr_t host_adr;
  host_data_t host_dat_w, host_dat_r;
  logic get_next_inst, take_branch;
  pc_t  branch_target;
  pc_t   [FETCH_WIDTH-1:0] if_pc, if_npc;
  inst_t [FETCH_WIDTH-1:0] if_ir;
  logic  [FETCH_WIDTH-1:0] if_valid;

  inst_t         model_inst [128];  // two per RAM word with the low half first
  pc_t           ref_pc;            // pc of the next bundle the core should see
  bundle_count_t accepted_count;
  logic [31:0]   lfsr;

  fetch_top dut (.*);

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  //////////////////////////////
  // random bits and reference
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic void reference_bundle(
    input  pc_t                     pc,
    output pc_t   [FETCH_WIDTH-1:0] exp_pc,
    output pc_t   [FETCH_WIDTH-1:0] exp_npc,
    output inst_t [FETCH_WIDTH-1:0] exp_ir,
    output logic  [FETCH_WIDTH-1:0] exp_valid
  );
    logic [6:0] low;  // index of the word's low half
    low = {pc[8:3], 1'b0};
    exp_pc[0]  = pc;
    exp_pc[1]  = pc + pc_t'(4);
    exp_npc[0] = pc;
    exp_npc[1] = pc[2] ? pc + pc_t'(4) : pc + pc_t'(8);  // mid-word entry steps 4
    exp_ir[0]  = model_inst[low];
    exp_ir[1]  = model_inst[low + 7'd1];
    exp_valid  = {1'b1, !pc[2]};
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_valid(input string name, input logic [FETCH_WIDTH-1:0] got,
                               input logic [FETCH_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_host(input string name, input host_data_t got, input host_data_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // one host bus cycle and its read data
  task automatic host_access(input logic we, input host_addr_t adr, input host_data_t wdata,
                             output host_data_t rdata);
    int waits;
    @(posedge clock);
    #5;
    host_cyc   = 1'b1;
    host_stb   = 1'b1;
    host_we    = we;
    host_adr   = adr;
    host_dat_w = wdata;
    waits      = 0;
    do
    begin
      @(negedge clock);
      waits++;
    end
    while (!host_ack && waits < 4);
    if (waits != 2)
    begin
      $display("host_ack did not arrive one cycle after the strobe");
      stop_run();
    end
    rdata = host_dat_r;
    @(posedge clock);
    #5;
    host_cyc = 1'b0;
    host_stb = 1'b0;
    if (host_ack)
    begin
      $display("host_ack stayed high for more than one cycle");
      stop_run();
    end
  endtask

  //////////////////////////////
  // bundle checker
  //////////////////////////////
  always @(negedge clock)
  begin
    pc_t   [FETCH_WIDTH-1:0] exp_pc, exp_npc;
    inst_t [FETCH_WIDTH-1:0] exp_ir;
    logic  [FETCH_WIDTH-1:0] exp_valid;
    if (!reset && get_next_inst && (if_valid != '0))
    begin
      reference_bundle(ref_pc, exp_pc, exp_npc, exp_ir, exp_valid);
      compare_valid("if_valid", if_valid, exp_valid);
      for (int s = 0; s < FETCH_WIDTH; s++)
      begin
        compare_pc($sformatf("if_pc[%0d]", s), if_pc[s], exp_pc[s]);
        if (exp_valid[s])
        begin
          compare_pc($sformatf("if_npc[%0d]", s), if_npc[s], exp_npc[s]);
          compare_inst($sformatf("if_ir[%0d]", s), if_ir[s], exp_ir[s]);
        end
      end
      accepted_count = accepted_count + bundle_count_t'(1);
      ref_pc = exp_npc[1];  // sequential step
    end
    if (take_branch)
      ref_pc = branch_target;  // branch wins over the step
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("timeout: the expected bundles did not all arrive");
    stop_run();
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial
  begin
    logic [31:0] r;
    host_data_t  rd;
    clock          = 1'b0;
    reset          = 1'b1;
    host_cyc       = 1'b0;
    host_stb       = 1'b0;
    host_we        = 1'b0;
    host_adr       = '0;
    host_dat_w     = '0;
    get_next_inst  = 1'b0;
    take_branch    = 1'b0;
    branch_target  = '0;
    ref_pc         = '0;
    accepted_count = '0;
    lfsr           = 32'hb95c;
    repeat (RESET_CYCLES) @(posedge clock);
    #5;
    reset = 1'b0;

    // fill the RAM and the model together
    for (int i = 0; i < 128; i++)
    begin
      take_bits(32, r);
      model_inst[i] = r;
      host_access(1'b1, HOST_IMEM_BASE + host_addr_t'(i), r, rd);
    end
    host_access(1'b1, HOST_BOOT_PC_ADDR, BOOT_PC, rd);
    ref_pc = pc_t'(BOOT_PC);
    host_access(1'b1, HOST_CTRL_ADDR, 32'h1, rd);  // setting run makes restart load the boot pc

    // random stalls and one-cycle branches
    while (accepted_count < NUM_BUNDLES)
    begin
      @(posedge clock);
      #5;
      if (accepted_count < NUM_BUNDLES)
      begin
        take_bits(2, r);
        get_next_inst = (r[1:0] != 2'b00);  // low one cycle in four
        take_bits(5, r);
        take_branch = (r[4:0] == 5'h00);
        take_bits(7, r);
        branch_target = pc_t'({r[6:0], 2'b00});  // bit 2 set half the time
      end
    end
    get_next_inst = 1'b0;
    take_branch   = 1'b0;

    // register readback
    host_access(1'b0, HOST_CTRL_ADDR, '0, rd);
    compare_host("ctrl", rd, 32'h1);
    host_access(1'b0, HOST_BOOT_PC_ADDR, '0, rd);
    compare_host("boot_pc", rd, BOOT_PC);
    host_access(1'b0, HOST_COUNT_ADDR, '0, rd);
    compare_host("bundle_count", rd, accepted_count);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_front.f
source/fetch_pkg.sv
source/fetch_stage.sv
source/imem_bus_master.sv
source/inst_ram.sv
source/fetch_control.sv
source/fetch_top.sv
verification/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
# the exit status follows the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f fetch_front.f --top-module fetch_tb -o fetch_sim &&
./obj_dir/fetch_sim 2>&1 | awk '{ print } /^TEST RESULT: PASS$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
